//--- tetris_board_pkg.sv
// board geometry for the falling-block game core
// rows are 10-bit words, row 0 sits on the floor

package tetris_board_pkg;

    // ----------------------------------------
    // board size
    // ----------------------------------------
    localparam int BOARD_COLS = 10;
    localparam int BOARD_ROWS = 22;
    localparam int ROW_IDX_W  = 5;

    // highest valid row index, for range checks on a row index
    localparam logic [ROW_IDX_W-1:0] TOP_ROW = ROW_IDX_W'(BOARD_ROWS - 1);

    // ----------------------------------------
    // spawn area
    // ----------------------------------------
    localparam int SPAWN_TOP = 21;
    localparam int SPAWN_LOW = 20;

    // one row of cells, bit 0 is the leftmost column
    typedef logic [BOARD_COLS-1:0] row_t;

endpackage

//--- tetris_game_pkg.sv
// game rules for the falling-block core
// state encoding, keycodes, piece shapes and scoring

package tetris_game_pkg;

    // ----------------------------------------
    // game FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        SPAWN = 2'd0,
        FALL  = 2'd1,
        LOCK  = 2'd2,
        CLEAR = 2'd3
    } state_t;

    // keyboard codes for a sideways shift
    localparam logic [7:0] KEY_LEFT  = 8'h04;
    localparam logic [7:0] KEY_RIGHT = 8'h07;

    // piece chooser starts here after reset
    localparam logic [2:0] LFSR_SEED = 3'b001;

    // ----------------------------------------
    // spawn shapes, columns 3 to 6
    // order is I, O, T, S, Z, J, L
    // ----------------------------------------
    localparam tetris_board_pkg::row_t PIECE_TOP [7] = '{
        10'h078, 10'h030, 10'h038, 10'h030, 10'h018, 10'h008, 10'h020
    };
    localparam tetris_board_pkg::row_t PIECE_LOW [7] = '{
        10'h000, 10'h030, 10'h010, 10'h018, 10'h030, 10'h038, 10'h038
    };

    // ----------------------------------------
    // scoring
    // ----------------------------------------
    localparam int SCORE_W = 16;
    localparam logic [SCORE_W-1:0] SCORE_PER_ROW  = SCORE_W'(10);
    localparam logic [SCORE_W-1:0] ROWS_PER_CLEAR = SCORE_W'(1);

endpackage

//--- piece_source.sv
// piece chooser: 3-bit LFSR that picks the next spawn shape
`timescale 1ns/1ps

module piece_source (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic                   step,
    output tetris_board_pkg::row_t spawn_top,
    output tetris_board_pkg::row_t spawn_low
);

    logic [2:0] lfsr;
    logic       feedback;
    logic [2:0] shape_idx;

    // taps at bits 2 and 1, walks all seven nonzero values
    assign feedback = lfsr[2] ^ lfsr[1];

    always_ff @(posedge Clk) begin
        if (reset) begin
            lfsr <= tetris_game_pkg::LFSR_SEED;
        end else if (step) begin
            lfsr <= {lfsr[1:0], feedback};
        end
    end

    // value 1 selects the first table entry
    assign shape_idx = lfsr - 3'd1;

    assign spawn_top = tetris_game_pkg::PIECE_TOP[shape_idx];
    assign spawn_low = tetris_game_pkg::PIECE_LOW[shape_idx];

endmodule

//--- falling_piece.sv
// falling layer: holds the active piece and moves it per step
// checks walls, settled cells and the floor before each move
`timescale 1ns/1ps

module falling_piece (
    input  logic                    Clk,
    input  logic                    reset,
    input  logic                    step,
    input  tetris_game_pkg::state_t state,
    input  logic [7:0]              keycode,
    input  tetris_board_pkg::row_t  spawn_top,
    input  tetris_board_pkg::row_t  spawn_low,
    input  tetris_board_pkg::row_t  settled_rows [tetris_board_pkg::BOARD_ROWS],
    output tetris_board_pkg::row_t  falling_rows [tetris_board_pkg::BOARD_ROWS],
    output logic                    landed,
    output logic                    spawn_blocked
);

    localparam int ROWS = tetris_board_pkg::BOARD_ROWS;
    localparam int COLS = tetris_board_pkg::BOARD_COLS;

    tetris_board_pkg::row_t moved   [ROWS];
    tetris_board_pkg::row_t layer_d [ROWS];
    logic left_ok;
    logic right_ok;
    logic go_left;
    logic go_right;
    logic layer_empty;

    // ----------------------------------------
    // sideways legality and landing
    // ----------------------------------------
    always_comb begin
        left_ok     = 1'b1;
        right_ok    = 1'b1;
        layer_empty = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            // edge column or a settled cell in the way
            if (falling_rows[r][0] || ((falling_rows[r] >> 1) & settled_rows[r]) != '0) begin
                left_ok = 1'b0;
            end
            if (falling_rows[r][COLS-1] ||
                ((falling_rows[r] << 1) & settled_rows[r]) != '0) begin
                right_ok = 1'b0;
            end
            if (falling_rows[r] != '0) begin
                layer_empty = 1'b0;
            end
        end

        go_left  = (state == tetris_game_pkg::FALL) &&
                   (keycode == tetris_game_pkg::KEY_LEFT) && left_ok;
        go_right = (state == tetris_game_pkg::FALL) &&
                   (keycode == tetris_game_pkg::KEY_RIGHT) && right_ok;

        for (int r = 0; r < ROWS; r++) begin
            if (go_left) begin
                moved[r] = falling_rows[r] >> 1;
            end else if (go_right) begin
                moved[r] = falling_rows[r] << 1;
            end else begin
                moved[r] = falling_rows[r];
            end
        end

        // floor, or a settled cell right below the shifted piece
        landed = (moved[0] != '0);
        for (int r = 1; r < ROWS; r++) begin
            if ((moved[r] & settled_rows[r-1]) != '0) begin
                landed = 1'b1;
            end
        end
    end

    assign spawn_blocked =
        ((spawn_top & settled_rows[tetris_board_pkg::SPAWN_TOP]) != '0) ||
        ((spawn_low & settled_rows[tetris_board_pkg::SPAWN_LOW]) != '0);

    // ----------------------------------------
    // next layer
    // ----------------------------------------
    always_comb begin
        layer_d = falling_rows;
        case (state)
            tetris_game_pkg::SPAWN: begin
                // only into an empty layer, so a blocked spawn stays put
                if (layer_empty) begin
                    layer_d = '{default: '0};
                    layer_d[tetris_board_pkg::SPAWN_TOP] = spawn_top;
                    layer_d[tetris_board_pkg::SPAWN_LOW] = spawn_low;
                end
            end
            tetris_game_pkg::FALL: begin
                if (landed) begin
                    layer_d = moved;
                end else begin
                    for (int r = 0; r < ROWS - 1; r++) begin
                        layer_d[r] = moved[r+1];
                    end
                    layer_d[ROWS-1] = '0;
                end
            end
            tetris_game_pkg::LOCK: begin
                // piece now lives in the settled layer
                layer_d = '{default: '0};
            end
            default: begin
                layer_d = falling_rows;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            falling_rows <= '{default: '0};
        end else if (step) begin
            falling_rows <= layer_d;
        end
    end

endmodule

//--- playfield.sv
// settled layer: locks landed pieces and removes full rows
// also serves the merged board one row at a time
`timescale 1ns/1ps

module playfield (
    input  logic                                Clk,
    input  logic                                reset,
    input  logic                                step,
    input  tetris_game_pkg::state_t             state,
    input  tetris_board_pkg::row_t              falling_rows [tetris_board_pkg::BOARD_ROWS],
    input  logic [tetris_board_pkg::ROW_IDX_W-1:0] view_row,
    output tetris_board_pkg::row_t              settled_rows [tetris_board_pkg::BOARD_ROWS],
    output logic                                full_found,
    output tetris_board_pkg::row_t              view_data
);

    localparam int ROWS = tetris_board_pkg::BOARD_ROWS;

    logic [ROWS-1:0] is_full;
    logic [ROWS-1:0] shift_down;
    tetris_board_pkg::row_t settled_d [ROWS];

    // ----------------------------------------
    // full rows
    // ----------------------------------------
    // every row at or above the lowest full one moves down
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            is_full[r] = &settled_rows[r];
        end
        shift_down[0] = is_full[0];
        for (int r = 1; r < ROWS; r++) begin
            shift_down[r] = shift_down[r-1] | is_full[r];
        end
    end

    assign full_found = shift_down[ROWS-1];

    always_comb begin
        settled_d = settled_rows;
        case (state)
            tetris_game_pkg::LOCK: begin
                for (int r = 0; r < ROWS; r++) begin
                    settled_d[r] = settled_rows[r] | falling_rows[r];
                end
            end
            tetris_game_pkg::CLEAR: begin
                for (int r = 0; r < ROWS - 1; r++) begin
                    if (shift_down[r]) begin
                        settled_d[r] = settled_rows[r+1];
                    end
                end
                // empty row enters at the top
                if (shift_down[ROWS-1]) begin
                    settled_d[ROWS-1] = '0;
                end
            end
            default: begin
                settled_d = settled_rows;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            settled_rows <= '{default: '0};
        end else if (step) begin
            settled_rows <= settled_d;
        end
    end

    // merged read port, rows past the top read as empty
    always_comb begin
        if (view_row <= tetris_board_pkg::TOP_ROW) begin
            view_data = settled_rows[view_row] | falling_rows[view_row];
        end else begin
            view_data = '0;
        end
    end

endmodule

//--- game_sequencer.sv
// game FSM with rows-cleared and score counters
// a blocked spawn ends the game and freezes the state
`timescale 1ns/1ps

module game_sequencer (
    input  logic                                Clk,
    input  logic                                reset,
    input  logic                                step,
    input  logic                                landed,
    input  logic                                spawn_blocked,
    input  logic                                full_found,
    output tetris_game_pkg::state_t             state,
    output logic [tetris_game_pkg::SCORE_W-1:0] score,
    output logic [tetris_game_pkg::SCORE_W-1:0] rows_cleared,
    output logic                                game_over
);

    always_ff @(posedge Clk) begin
        if (reset) begin
            state        <= tetris_game_pkg::SPAWN;
            score        <= '0;
            rows_cleared <= '0;
            game_over    <= 1'b0;
        end else if (step && !game_over) begin
            case (state)
                tetris_game_pkg::SPAWN: begin
                    if (spawn_blocked) begin
                        game_over <= 1'b1;
                    end else begin
                        state <= tetris_game_pkg::FALL;
                    end
                end
                tetris_game_pkg::FALL: begin
                    if (landed) begin
                        state <= tetris_game_pkg::LOCK;
                    end
                end
                tetris_game_pkg::LOCK: begin
                    state <= tetris_game_pkg::CLEAR;
                end
                tetris_game_pkg::CLEAR: begin
                    // one full row per step until none is left
                    if (full_found) begin
                        rows_cleared <= rows_cleared + tetris_game_pkg::ROWS_PER_CLEAR;
                        score        <= score + tetris_game_pkg::SCORE_PER_ROW;
                    end else begin
                        state <= tetris_game_pkg::SPAWN;
                    end
                end
                default: begin
                    state <= tetris_game_pkg::SPAWN;
                end
            endcase
        end
    end

endmodule

//--- tetris_top.sv
// falling-block game core, top level
// sequencer, piece chooser and the two board layers
`timescale 1ns/1ps

module tetris_top (
    input  logic                                   Clk,
    input  logic                                   reset,
    input  logic                                   step,
    input  logic [7:0]                             keycode,
    input  logic [tetris_board_pkg::ROW_IDX_W-1:0] view_row,
    output tetris_board_pkg::row_t                 view_data,
    output logic [tetris_game_pkg::SCORE_W-1:0]    score,
    output logic [tetris_game_pkg::SCORE_W-1:0]    rows_cleared,
    output logic                                   game_over
);

    tetris_game_pkg::state_t state;
    tetris_board_pkg::row_t  spawn_top;
    tetris_board_pkg::row_t  spawn_low;
    tetris_board_pkg::row_t  settled_rows [tetris_board_pkg::BOARD_ROWS];
    tetris_board_pkg::row_t  falling_rows [tetris_board_pkg::BOARD_ROWS];
    logic landed;
    logic spawn_blocked;
    logic full_found;

    game_sequencer u_sequencer (
        .Clk(Clk), .reset(reset), .step(step),
        .landed(landed), .spawn_blocked(spawn_blocked), .full_found(full_found),
        .state(state), .score(score), .rows_cleared(rows_cleared), .game_over(game_over)
    );

    piece_source u_source (
        .Clk(Clk), .reset(reset), .step(step),
        .spawn_top(spawn_top), .spawn_low(spawn_low)
    );

    falling_piece u_falling (
        .Clk(Clk), .reset(reset), .step(step), .state(state), .keycode(keycode),
        .spawn_top(spawn_top), .spawn_low(spawn_low),
        .settled_rows(settled_rows), .falling_rows(falling_rows),
        .landed(landed), .spawn_blocked(spawn_blocked)
    );

    playfield u_playfield (
        .Clk(Clk), .reset(reset), .step(step), .state(state),
        .falling_rows(falling_rows), .view_row(view_row),
        .settled_rows(settled_rows), .full_found(full_found), .view_data(view_data)
    );

endmodule

//--- tb_clock_gen.sv
// testbench clock and reset source
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic Clk,
    output logic reset
);

    initial begin
        Clk = 1'b0;
        forever #(PERIOD / 2.0) Clk = ~Clk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        #(PERIOD * RESET_CYCLES);
        reset = 1'b0;
    end

endmodule

//--- tb_tetris.sv
// testbench for the game core, replays a step trace
// and checks counters and one board row after each group of steps
`timescale 1ns/1ps

module tb_tetris;

    localparam int MAX_LINES = 64;
    localparam int FIELDS    = 7;

    logic                                   Clk;
    logic                                   reset;
    logic                                   step;
    logic [7:0]                             keycode;
    logic [tetris_board_pkg::ROW_IDX_W-1:0] view_row;
    tetris_board_pkg::row_t                 view_data;
    logic [tetris_game_pkg::SCORE_W-1:0]    score;
    logic [tetris_game_pkg::SCORE_W-1:0]    rows_cleared;
    logic                                   game_over;

    logic [15:0] trace_mem [MAX_LINES*FIELDS];
    int cycle_count = 0;
    int cycle_limit = 1_000_000;

    tb_clock_gen u_clock (
        .Clk(Clk),
        .reset(reset)
    );

    tetris_top u_dut (
        .Clk(Clk), .reset(reset), .step(step), .keycode(keycode),
        .view_row(view_row), .view_data(view_data),
        .score(score), .rows_cleared(rows_cleared), .game_over(game_over)
    );

    // ----------------------------------------
    // reporting and compare tasks
    // ----------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_row(input tetris_board_pkg::row_t got,
                               input tetris_board_pkg::row_t exp, input int row);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t ns: row %0d reads %h, expected %h",
                                     $time, row, got, exp));
        end
    endtask

    task automatic compare_count(input logic [tetris_game_pkg::SCORE_W-1:0] got,
                                 input logic [tetris_game_pkg::SCORE_W-1:0] exp,
                                 input string name);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_flag(input bit got, input bit exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t ns: game_over is %0b, expected %0b",
                                     $time, got, exp));
        end
    endtask

    // one strobe cycle, then one idle cycle
    task automatic apply_step(input logic [7:0] key);
        @(negedge Clk);
        step    = 1'b1;
        keycode = key;
        @(negedge Clk);
        step    = 1'b0;
    endtask

    // ----------------------------------------
    // timeout
    // ----------------------------------------
    always @(posedge Clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int line;
        int base;
        int total_steps;
        tetris_board_pkg::row_t exp_row;

        step     = 1'b0;
        keycode  = 8'h00;
        view_row = '0;

        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("tetris_trace.txt", trace_mem);

        // a zero step count marks the end of the trace
        total_steps = 0;
        line = 0;
        while (line < MAX_LINES && trace_mem[line*FIELDS] != 0) begin
            total_steps += int'(trace_mem[line*FIELDS]);
            line++;
        end
        if (total_steps == 0) begin
            report_failure("The trace file held no steps to run");
        end
        cycle_limit = total_steps * 4 + 20;

        @(negedge reset);
        @(negedge Clk);

        // empty board and cleared counters out of reset
        for (int r = 0; r < tetris_board_pkg::BOARD_ROWS; r++) begin
            view_row = r[tetris_board_pkg::ROW_IDX_W-1:0];
            #1;
            compare_row(view_data, '0, r);
        end
        compare_count(score, '0, "score");
        compare_count(rows_cleared, '0, "rows_cleared");
        compare_flag(game_over, 1'b0);

        line = 0;
        while (line < MAX_LINES && trace_mem[line*FIELDS] != 0) begin
            base = line * FIELDS;
            repeat (trace_mem[base]) apply_step(trace_mem[base+1][7:0]);
            @(negedge Clk);
            compare_count(score, trace_mem[base+2], "score");
            compare_count(rows_cleared, trace_mem[base+3], "rows_cleared");
            compare_flag(game_over, trace_mem[base+4][0]);
            view_row = trace_mem[base+5][tetris_board_pkg::ROW_IDX_W-1:0];
            exp_row  = trace_mem[base+6][tetris_board_pkg::BOARD_COLS-1:0];
            #1;
            compare_row(view_data, exp_row, int'(view_row));
            line++;
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tetris_trace.txt
// columns (hex): steps keycode score rows_cleared game_over row view_data
// checks are taken after the last step of each line
01 00 0000 0000 0 15 078
03 04 0000 0000 0 12 00F
01 04 0000 0000 0 11 00F
11 00 0000 0000 0 00 00F
03 00 0000 0000 0 00 00F
01 00 0000 0000 0 14 038
04 07 0000 0000 0 10 380
01 07 0000 0000 0 0F 380
0F 00 0000 0000 0 00 38F
03 00 0000 0000 0 01 200
01 00 0000 0000 0 15 078
03 04 0000 0000 0 12 00F
11 00 0000 0000 0 01 20F
03 00 0000 0000 0 00 38F
01 00 0000 0000 0 14 010
03 04 0000 0000 0 11 002
0F 00 0000 0000 0 03 007
03 00 0000 0000 0 02 002
01 00 0000 0000 0 15 020
01 07 0000 0000 0 13 070
13 00 0000 0000 0 00 3FF
01 00 0000 0000 0 01 24F
01 00 0000 0000 0 00 3FF
01 00 000A 0001 0 00 24F
01 00 000A 0001 0 02 007
18 00 000A 0001 0 01 032
16 00 000A 0001 0 02 03F
14 00 000A 0001 0 05 008
12 00 000A 0001 0 07 020
10 00 000A 0001 0 09 030
0E 00 000A 0001 0 0B 038
0C 00 000A 0001 0 0D 038
0A 00 000A 0001 0 0F 030
08 00 000A 0001 0 11 020
06 00 000A 0001 0 13 008
04 00 000A 0001 0 14 038
01 00 000A 0001 1 15 030
06 07 000A 0001 1 15 030
03 04 000A 0001 1 00 27F

//--- flist.f
tetris_board_pkg.sv
tetris_game_pkg.sv
piece_source.sv
falling_piece.sv
playfield.sv
game_sequencer.sv
tetris_top.sv
tb_clock_gen.sv
tb_tetris.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tetris
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the trace testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
